/* logic/alu_pkg.sv */
// Arithmetic card constants
package alu_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Data path
   ///////////////////////////////////////////////////////////////////////

   localparam int DATA_W = 16;               // One processor word

   ///////////////////////////////////////////////////////////////////////
   // Microcode field codes
   ///////////////////////////////////////////////////////////////////////

   // Read address bits 4:3 select the card, bits 2:0 carry the operation
   localparam logic [1:0] RADDR_ALU   = 2'b01;
   localparam logic [4:0] WADDR_ALU_B = 5'h0a; // Load port B from the bus

   localparam logic [3:0] ACT_CLL = 4'h4;    // Clear L
   localparam logic [3:0] ACT_CPL = 4'h5;    // Complement L
   localparam logic [3:0] ACT_SRU = 4'h6;    // Start shift/rotate

   ///////////////////////////////////////////////////////////////////////
   // Operation table
   ///////////////////////////////////////////////////////////////////////

   localparam logic [2:0] OP_ADD  = 3'd0;    // A + B
   localparam logic [2:0] OP_AND  = 3'd1;
   localparam logic [2:0] OP_OR   = 3'd2;
   localparam logic [2:0] OP_XOR  = 3'd3;
   localparam logic [2:0] OP_NOTA = 3'd4;    // ~A
   localparam logic [2:0] OP_A    = 3'd5;
   localparam logic [2:0] OP_B    = 3'd6;
   localparam logic [2:0] OP_ADC  = 3'd7;    // A + B + L

   // Bus bit positions used by flag writes
   localparam int FLAG_L_BIT = 12;
   localparam int FLAG_V_BIT = 13;

endpackage

/* logic/alu_decoder.sv */
// Microcode field decoder
`timescale 1ns/1ns

module alu_decoder (
   input  logic       clk4,
   input  logic       arst_n,
   input  logic [4:0] raddr,               // Read address field
   input  logic [4:0] waddr,               // Write address field
   input  logic [3:0] action,              // Action field
   output logic       alu_read,            // Card drives the bus this cycle
   output logic [2:0] op,                  // Operation select
   output logic       write_b,             // Load port B
   output logic       act_cll,
   output logic       act_cpl,
   output logic       act_sru
);

   ///////////////////////////////////////////////////////////////////////
   // Field matching
   ///////////////////////////////////////////////////////////////////////

   // Top two raddr bits pick this card, the rest is the op
   assign alu_read = (raddr[4:3] == alu_pkg::RADDR_ALU);
   assign op       = raddr[2:0];

   assign write_b  = (waddr == alu_pkg::WADDR_ALU_B);

   // Actions are mutually exclusive codes on one field
   assign act_cll  = (action == alu_pkg::ACT_CLL);
   assign act_cpl  = (action == alu_pkg::ACT_CPL);
   assign act_sru  = (action == alu_pkg::ACT_SRU);

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////

   // An undefined field would fire stray strobes into the flag and shifter logic
   a_fields_known : assert property (
      @(posedge clk4) disable iff (!arst_n)
      !$isunknown({raddr, waddr, action})
   ) else $error("alu_decoder: microcode field unknown");

endmodule

/* logic/alu_operand_regs.sv */
// ALU operand registers
`timescale 1ns/1ns

module alu_operand_regs (
   input  logic                        clk4,
   input  logic                        arst_n,
   input  logic [alu_pkg::DATA_W-1:0]  ac,       // Accumulator
   input  logic [alu_pkg::DATA_W-1:0]  ibus_in,  // Bus write data
   input  logic                        write_b,  // Bus write to port B
   input  logic                        sru_step, // Shifter step this cycle
   input  logic [alu_pkg::DATA_W-1:0]  sru_b,    // Next B from the shifter
   output logic [alu_pkg::DATA_W-1:0]  a,
   output logic [alu_pkg::DATA_W-1:0]  b
);

   // Port A tracks the accumulator one cycle late
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         a <= '0;
      end else begin
         a <= ac;
      end
   end

   // Port B: bus write, else shifter step, else hold
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         b <= '0;
      end else if (write_b) begin
         b <= ibus_in;                     // Processor bus load
      end else if (sru_step) begin
         b <= sru_b;                       // Partial shift result
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////

   // The microcode must leave B alone while the shifter owns it
   a_no_write_while_step : assert property (
      @(posedge clk4) disable iff (!arst_n)
      !(write_b && sru_step)
   ) else $error("alu_operand_regs: port B written during shift");

endmodule

/* logic/alu_op_unit.sv */
// ALU operation table
`timescale 1ns/1ns

module alu_op_unit (
   input  logic        alu_read,           // Read strobe from the decoder
   input  logic [2:0]  op,
   input  logic [15:0] a,
   input  logic [15:0] b,
   input  logic        fl,                 // Current link, for ADC
   output logic [15:0] ibus_out,
   output logic        ibus_oe,
   output logic        carry_out,          // Adder carry candidate
   output logic        ovf_out,            // Signed overflow candidate
   output logic        add_valid           // Store flags from this read
);

   logic        carry_in;
   logic [16:0] sum;                       // Carry in bit 16
   logic [15:0] result;
   logic        is_add;

   ///////////////////////////////////////////////////////////////////////
   // Adder
   ///////////////////////////////////////////////////////////////////////

   assign carry_in = (op == alu_pkg::OP_ADC) ? fl : 1'b0;
   assign sum      = {1'b0, a} + {1'b0, b} + {16'd0, carry_in};

   assign carry_out = sum[16];
   // Same operand signs, different result sign
   assign ovf_out   = (a[15] == b[15]) && (sum[15] != a[15]);

   ///////////////////////////////////////////////////////////////////////
   // Operation table
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (op)
         alu_pkg::OP_ADD:  result = sum[15:0];
         alu_pkg::OP_AND:  result = a & b;
         alu_pkg::OP_OR:   result = a | b;
         alu_pkg::OP_XOR:  result = a ^ b;
         alu_pkg::OP_NOTA: result = ~a;
         alu_pkg::OP_A:    result = a;
         alu_pkg::OP_B:    result = b;     // Also the shifter result read
         alu_pkg::OP_ADC:  result = sum[15:0];
         default:          result = '0;
      endcase
   end

   // Only add reads update L and V
   assign is_add    = (op == alu_pkg::OP_ADD) || (op == alu_pkg::OP_ADC);
   assign add_valid = alu_read && is_add;

   // Bus driver, quiet when not selected
   assign ibus_oe  = alu_read;
   assign ibus_out = alu_read ? result : 16'd0;

endmodule

/* logic/alu_sru.sv */
// Serial shift and rotate unit
`timescale 1ns/1ns

module alu_sru (
   input  logic                        clk4,
   input  logic                        arst_n,
   input  logic                        act_sru,  // Start strobe
   input  logic [6:0]                  ir,       // Operand field of the instruction
   input  logic [alu_pkg::DATA_W-1:0]  b,        // Current port B
   input  logic                        fl,       // Current link
   output logic                        sru_step, // Apply sru_b and sru_l this cycle
   output logic [alu_pkg::DATA_W-1:0]  sru_b,
   output logic                        sru_l,
   output logic                        sru_busy
);

   logic [3:0] cnt;                        // Steps still to do
   logic       op_right;                   // 1 = right
   logic       op_arith;                   // Sign fill on right shift
   logic       op_rotate;                  // Through the L/B ring
   logic       fill;                       // Bit entering B

   ///////////////////////////////////////////////////////////////////////
   // Control
   ///////////////////////////////////////////////////////////////////////

   // A zero distance never raises busy
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         sru_busy  <= 1'b0;
         cnt       <= '0;
         op_right  <= 1'b0;
         op_arith  <= 1'b0;
         op_rotate <= 1'b0;
      end else if (act_sru) begin
         sru_busy  <= (ir[3:0] != 4'd0);
         cnt       <= ir[3:0];             // Distance
         op_right  <= ir[4];
         op_arith  <= ir[5];
         op_rotate <= ir[6];
      end else if (sru_busy) begin
         cnt <= cnt - 4'd1;
         if (cnt == 4'd1) begin
            sru_busy <= 1'b0;              // Last step done this edge
         end
      end
   end

   assign sru_step = sru_busy;             // One step per busy cycle

   ///////////////////////////////////////////////////////////////////////
   // One step
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      if (op_rotate) begin
         fill = fl;                        // L rejoins the ring
      end else if (op_right && op_arith) begin
         fill = b[alu_pkg::DATA_W-1];      // Sign copy
      end else begin
         fill = 1'b0;
      end
   end

   always_comb begin
      if (op_right) begin
         sru_l = b[0];
         sru_b = {fill, b[alu_pkg::DATA_W-1:1]};
      end else begin
         sru_l = b[alu_pkg::DATA_W-1];
         sru_b = {b[alu_pkg::DATA_W-2:0], fill};
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////

   // Restarting mid-operation would corrupt the partial result in B
   a_no_restart : assert property (
      @(posedge clk4) disable iff (!arst_n)
      !(act_sru && sru_busy)
   ) else $error("alu_sru: start while busy");

endmodule

/* logic/alu_flags.sv */
// Link and overflow flags
`timescale 1ns/1ns

module alu_flags (
   input  logic        clk4,
   input  logic        arst_n,
   input  logic        flag_we,            // Load L and V from the bus
   input  logic [15:0] ibus_in,
   input  logic        add_valid,          // Add read this cycle
   input  logic        carry_out,
   input  logic        ovf_out,
   input  logic        act_cll,
   input  logic        act_cpl,
   input  logic        sru_step,
   input  logic        sru_l,              // Bit shifted out of B
   output logic        fl,
   output logic        fv
);

   ///////////////////////////////////////////////////////////////////////
   // Link
   ///////////////////////////////////////////////////////////////////////

   // Shifter first, then flag write, add, CLL, CPL
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         fl <= 1'b0;
      end else if (sru_step) begin
         fl <= sru_l;
      end else if (flag_we) begin
         fl <= ibus_in[alu_pkg::FLAG_L_BIT];
      end else if (add_valid) begin
         fl <= fl ^ carry_out;             // Carry toggles L
      end else if (act_cll) begin
         fl <= 1'b0;
      end else if (act_cpl) begin
         fl <= ~fl;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Overflow
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         fv <= 1'b0;
      end else if (flag_we) begin
         fv <= ibus_in[alu_pkg::FLAG_V_BIT];
      end else if (add_valid) begin
         fv <= ovf_out;                    // Shifts leave V alone
      end
   end

   // A flag write would be lost under a shift step
   a_no_flag_write_in_shift : assert property (
      @(posedge clk4) disable iff (!arst_n)
      !(flag_we && sru_step)
   ) else $error("alu_flags: flag write during shift");

endmodule

/* logic/card_alu.sv */
// Arithmetic card top level
`timescale 1ns/1ns

module card_alu (
   input  logic                        clk4,
   input  logic                        arst_n,
   input  logic [4:0]                  raddr,    // Microcode fields
   input  logic [4:0]                  waddr,
   input  logic [3:0]                  action,
   input  logic [alu_pkg::DATA_W-1:0]  ibus_in,
   input  logic [alu_pkg::DATA_W-1:0]  ac,
   input  logic [6:0]                  ir,       // Shift operand
   input  logic                        flag_we,
   output logic [alu_pkg::DATA_W-1:0]  ibus_out,
   output logic                        ibus_oe,
   output logic                        fl,
   output logic                        fv,
   output logic                        sru_busy
);

   ///////////////////////////////////////////////////////////////////////
   // Internal nets
   ///////////////////////////////////////////////////////////////////////

   logic                       alu_read;
   logic [2:0]                 op;
   logic                       write_b;
   logic                       act_cll;
   logic                       act_cpl;
   logic                       act_sru;
   logic [alu_pkg::DATA_W-1:0] a;
   logic [alu_pkg::DATA_W-1:0] b;
   logic                       carry_out;
   logic                       ovf_out;
   logic                       add_valid;
   logic                       sru_step;
   logic [alu_pkg::DATA_W-1:0] sru_b;
   logic                       sru_l;

   ///////////////////////////////////////////////////////////////////////
   // Blocks
   ///////////////////////////////////////////////////////////////////////

   alu_decoder i_decoder (
      .clk4(clk4), .arst_n(arst_n),
      .raddr(raddr), .waddr(waddr), .action(action),
      .alu_read(alu_read), .op(op), .write_b(write_b),
      .act_cll(act_cll), .act_cpl(act_cpl), .act_sru(act_sru)
   );

   alu_operand_regs i_operand_regs (
      .clk4(clk4), .arst_n(arst_n),
      .ac(ac), .ibus_in(ibus_in), .write_b(write_b),
      .sru_step(sru_step), .sru_b(sru_b), .a(a), .b(b)
   );

   alu_op_unit i_op_unit (
      .alu_read(alu_read), .op(op), .a(a), .b(b), .fl(fl),
      .ibus_out(ibus_out), .ibus_oe(ibus_oe),
      .carry_out(carry_out), .ovf_out(ovf_out), .add_valid(add_valid)
   );

   alu_sru i_sru (
      .clk4(clk4), .arst_n(arst_n),
      .act_sru(act_sru), .ir(ir), .b(b), .fl(fl),
      .sru_step(sru_step), .sru_b(sru_b), .sru_l(sru_l), .sru_busy(sru_busy)
   );

   alu_flags i_flags (
      .clk4(clk4), .arst_n(arst_n),
      .flag_we(flag_we), .ibus_in(ibus_in),
      .add_valid(add_valid), .carry_out(carry_out), .ovf_out(ovf_out),
      .act_cll(act_cll), .act_cpl(act_cpl),
      .sru_step(sru_step), .sru_l(sru_l), .fl(fl), .fv(fv)
   );

endmodule

/* sim/tb_card_alu.sv */
// Card ALU testbench
`timescale 1ns/1ns

module tb_card_alu;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_VEC    = 23;         // Vectors in the stimulus file

   logic        clk4;
   logic        arst_n;
   logic [4:0]  raddr;
   logic [4:0]  waddr;
   logic [3:0]  action;
   logic [15:0] ibus_in;
   logic [15:0] ac;
   logic [6:0]  ir;
   logic        flag_we;
   logic [15:0] ibus_out;
   logic        ibus_oe;
   logic        fl;
   logic        fv;
   logic        sru_busy;

   logic [83:0] stim_mem [NUM_VEC];        // One command per word
   logic [31:0] lfsr_state;

   // Fields of the current vector
   logic [3:0]  v_kind;
   logic [15:0] v_ac;
   logic [15:0] v_b;
   logic [6:0]  v_ir;
   logic [15:0] v_fw;                      // Flag write word
   logic [15:0] v_bus;                     // Expected bus value
   logic        v_l;
   logic        v_v;

   card_alu i_card_alu (
      .clk4(clk4), .arst_n(arst_n),
      .raddr(raddr), .waddr(waddr), .action(action),
      .ibus_in(ibus_in), .ac(ac), .ir(ir), .flag_we(flag_we),
      .ibus_out(ibus_out), .ibus_oe(ibus_oe),
      .fl(fl), .fv(fv), .sru_busy(sru_busy)
   );

   initial begin
      clk4 = 1'b0;
      forever #(CLK_PERIOD / 2) clk4 = ~clk4;
   end

   // Worst case per vector is a distance-15 shift plus gap, about 24 cycles
   initial begin
      #((NUM_VEC * 24 + 8) * CLK_PERIOD);
      $display("Watchdog timeout: the test sequence did not finish in time");
      $display("=== FAIL ===");
      $fatal(1, "Watchdog expired");
   end

   ///////////////////////////////////////////////////////////////////////
   // Checks and random gaps
   ///////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
      assert (got === expected) else begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, expected);
         $display("=== FAIL ===");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic expected);
      assert (got === expected) else begin
         $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, expected);
         $display("=== FAIL ===");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Galois form, right shift
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end else begin
         return state >> 1;
      end
   endfunction

   task automatic draw_bit(output logic rnd);
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      rnd        = lfsr_state[0];
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Bus cycles
   ///////////////////////////////////////////////////////////////////////

   task automatic issue_cycle(input logic [4:0] raddr_v, input logic [4:0] waddr_v,
                              input logic [3:0] action_v, input logic flag_we_v,
                              input logic [15:0] ibus_v);
      @(posedge clk4);
      raddr   <= raddr_v;
      waddr   <= waddr_v;
      action  <= action_v;
      flag_we <= flag_we_v;
      ibus_in <= ibus_v;
      ac      <= v_ac;                     // Held for the whole vector
      ir      <= v_ir;
   endtask

   task automatic issue_idle();
      issue_cycle(5'h00, 5'h00, 4'h0, 1'b0, 16'h0000);
   endtask

   // Just before the next rising edge
   task automatic wait_sample();
      #(CLK_PERIOD - 1);
   endtask

   task automatic idle_gap();
      logic       rnd_hi;
      logic       rnd_lo;
      logic [1:0] gap;
      draw_bit(rnd_hi);
      draw_bit(rnd_lo);
      gap = {rnd_hi, rnd_lo};              // Zero to three cycles
      repeat (gap) begin
         issue_idle();
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Commands
   ///////////////////////////////////////////////////////////////////////

   task automatic unpack_vector(input int idx);
      assert (!$isunknown(stim_mem[idx])) else begin
         $display("Stimulus file entry %0d is missing or malformed", idx);
         $display("=== FAIL ===");
         $fatal(1, "Bad stimulus entry");
      end
      v_kind = stim_mem[idx][83:80];
      v_ac   = stim_mem[idx][79:64];
      v_b    = stim_mem[idx][63:48];
      v_ir   = stim_mem[idx][46:40];
      v_fw   = stim_mem[idx][39:24];
      v_bus  = stim_mem[idx][23:8];
      v_l    = stim_mem[idx][4];
      v_v    = stim_mem[idx][0];
   endtask

   // B from the bus, then L and V from the flag word
   task automatic load_operands();
      issue_cycle(5'h00, alu_pkg::WADDR_ALU_B, 4'h0, 1'b0, v_b);
      issue_cycle(5'h00, 5'h00, 4'h0, 1'b1, v_fw);
   endtask

   task automatic run_alu_read(input logic [2:0] op_v);
      issue_cycle({alu_pkg::RADDR_ALU, op_v}, 5'h00, 4'h0, 1'b0, 16'h0000);
      wait_sample();
      check_bit("ibus_oe", ibus_oe, 1'b1);
      check_word("ibus_out", ibus_out, v_bus);
      issue_idle();
      wait_sample();                       // Flags settle on the read edge
      check_bit("ibus_oe", ibus_oe, 1'b0);
      check_bit("fl", fl, v_l);
      check_bit("fv", fv, v_v);
   endtask

   task automatic run_flag_cmd(input logic [3:0] action_v);
      issue_cycle(5'h00, 5'h00, action_v, 1'b0, 16'h0000);
      issue_idle();
      wait_sample();
      check_bit("fl", fl, v_l);
      check_bit("fv", fv, v_v);
   endtask

   task automatic run_shift();
      logic [15:0] busy_cycles;
      issue_cycle(5'h00, 5'h00, alu_pkg::ACT_SRU, 1'b0, 16'h0000);
      issue_idle();
      wait_sample();
      check_bit("sru_busy", sru_busy, (v_ir[3:0] != 4'd0)); // No busy at distance 0
      busy_cycles = 16'd0;
      while (sru_busy) begin
         busy_cycles = busy_cycles + 16'd1;
         issue_idle();
         wait_sample();
      end
      check_word("sru_busy cycles", busy_cycles, {12'd0, v_ir[3:0]});
      // Shifted word comes back through the B read
      issue_cycle({alu_pkg::RADDR_ALU, alu_pkg::OP_B}, 5'h00, 4'h0, 1'b0, 16'h0000);
      wait_sample();
      check_bit("ibus_oe", ibus_oe, 1'b1);
      check_word("ibus_out", ibus_out, v_bus);
      check_bit("fl", fl, v_l);
      check_bit("fv", fv, v_v);
      issue_idle();
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Sequence
   ///////////////////////////////////////////////////////////////////////

   initial begin
      arst_n     = 1'b0;
      raddr      = 5'h00;
      waddr      = 5'h00;
      action     = 4'h0;
      ibus_in    = 16'h0000;
      ac         = 16'h0000;
      ir         = 7'h00;
      flag_we    = 1'b0;
      v_ac       = 16'h0000;
      v_ir       = 7'h00;
      lfsr_state = 32'h3eda_99c4;
      $readmemh("sim/alu_stim.mem", stim_mem);

      repeat (3) @(posedge clk4);
      arst_n <= 1'b1;

      // Quiet card out of reset
      issue_idle();
      wait_sample();
      check_bit("ibus_oe", ibus_oe, 1'b0);
      check_bit("sru_busy", sru_busy, 1'b0);
      check_bit("fl", fl, 1'b0);
      check_bit("fv", fv, 1'b0);

      for (int i = 0; i < NUM_VEC; i++) begin
         unpack_vector(i);
         load_operands();
         case (v_kind)
            4'h0, 4'h1, 4'h2, 4'h3,
            4'h4, 4'h5, 4'h6, 4'h7: run_alu_read(v_kind[2:0]);
            4'h8:    run_flag_cmd(alu_pkg::ACT_CLL);
            4'h9:    run_flag_cmd(alu_pkg::ACT_CPL);
            4'hA:    run_flag_cmd(4'h0);   // Flag write alone
            4'hB:    run_shift();
            default: begin
               $display("Unknown command kind %h in stimulus entry %0d", v_kind, i);
               $display("=== FAIL ===");
               $fatal(1, "Bad command kind");
            end
         endcase
         idle_gap();
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

/* card_alu.f */
logic/alu_pkg.sv
logic/alu_decoder.sv
logic/alu_operand_regs.sv
logic/alu_op_unit.sv
logic/alu_sru.sv
logic/alu_flags.sv
logic/card_alu.sv
sim/tb_card_alu.sv

/* Makefile */
# Verilator build and run for the card ALU testbench
TOP = tb_card_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f card_alu.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* sim/alu_stim.mem */
// kind_ac_b_ir_flagword_expbus_expl_expv
// kind 0-7 ALU read with that op, 8 CLL, 9 CPL, A flag write only, B shift/rotate
1_F0F0_3C3C_00_3000_3030_1_1
2_1234_00FF_00_0000_12FF_0_0
3_AAAA_FFFF_00_1000_5555_1_0
4_0F0F_1234_00_2000_F0F0_0_1
5_BEEF_0000_00_3000_BEEF_1_1
6_0000_CAFE_00_0000_CAFE_0_0
0_1234_1111_00_0000_2345_0_0
0_FFFF_0001_00_1000_0000_0_0
0_7FFF_0001_00_0000_8000_0_1
0_8000_8000_00_2000_0000_1_1
7_1000_0FFF_00_1000_2000_1_0
7_FFFF_0000_00_1000_0000_0_0
8_0000_0000_00_3000_0000_0_1
9_0000_0000_00_2000_0000_1_1
A_0000_0000_00_EFFF_0000_0_1
B_0000_1234_04_0000_2340_1_0
B_0000_8005_13_3000_1000_1_1
B_0000_8F00_35_0000_FC78_0_0
B_0000_FFFF_1F_0000_0001_1_0
B_0000_8001_41_0000_0002_1_0
B_0000_0003_5F_1000_000E_0_0
B_0000_ABCD_40_3000_ABCD_1_1
B_0000_0001_4F_0000_8000_0_0
